// ==== pw_pkg.sv ====
//==========================================================================
// Shared sizes and types of the partial-write shim
// Line, mask and queue geometry, the slot heap size, the request and
// response structs, and the metadata tag with its two decodings
//==========================================================================

`default_nettype none

package pw_pkg;

    //======================================================================
    // Sizes
    //======================================================================

    // Bytes in one memory line, which is also the width of the byte mask
    localparam int DATA_BYTES = 8;
    // Line address width
    localparam int ADDR_W = 32;
    // Partial writes that may wait for their read data at once
    localparam int SLOTS = 4;
    localparam int SLOT_W = 2;
    // Metadata carried with every request and returned with the response
    localparam int TAG_W = 8;
    // Incoming write buffer and its back-pressure threshold
    localparam int QUEUE_DEPTH = 8;
    localparam int ALMOST_FULL_LEVEL = 5;

    //======================================================================
    // Types
    //======================================================================

    typedef logic [DATA_BYTES-1:0][7:0] line_t;
    typedef logic [DATA_BYTES-1:0] mask_t;

    // The requester sees the tag as opaque and must keep the top bit clear.
    // Reads injected by the shim set the top bit and carry the heap slot
    typedef union packed
    {
        logic [TAG_W-1:0] opaque;
        struct packed
        {
            logic is_merge;
            logic [SLOT_W-1:0] slot;
            logic [TAG_W-SLOT_W-2:0] spare;
        } view;
    } tag_u;

    typedef struct packed
    {
        logic valid;
        logic [ADDR_W-1:0] addr;
        line_t data;
        mask_t mask;
        tag_u tag;
    } wr_req_t;

    typedef struct packed
    {
        logic valid;
        logic [ADDR_W-1:0] addr;
        tag_u tag;
    } rd_req_t;

    typedef struct packed
    {
        logic valid;
        tag_u tag;
        line_t data;
    } rd_rsp_t;

    // A partial write held until the old contents of its line return
    typedef struct packed
    {
        logic [ADDR_W-1:0] addr;
        line_t data;
        mask_t mask;
        tag_u tag;
    } parked_t;

endpackage

`default_nettype wire

// ==== pw_write_queue.sv ====
//==========================================================================
// Incoming write buffer of the partial-write shim
// Circular buffer with occupancy count, registered almost-full, and
// a full-line or partial classification of the head entry
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_write_queue
(
    input  wire                   clk,
    input  wire                   reset,

    // Requester side
    input  wire pw_pkg::wr_req_t  wr_in,
    output logic                  wr_almost_full,

    // Head of the queue, taken by exactly one consumer per cycle
    output pw_pkg::wr_req_t       head,
    output logic                  head_partial,
    input  wire                   plain_pop,
    input  wire                   inject_pop
);

    pw_pkg::wr_req_t entries [pw_pkg::QUEUE_DEPTH];

    logic [$clog2(pw_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(pw_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    logic [$clog2(pw_pkg::QUEUE_DEPTH):0] count;
    logic [$clog2(pw_pkg::QUEUE_DEPTH):0] count_next;
    logic push;
    logic pop;

    // Every valid pulse is absorbed, including the two-cycle allowance
    assign push = wr_in.valid;
    // Full-line heads leave toward the write port, partial ones toward the
    // read path, and the two never coincide
    assign pop = plain_pop || inject_pop;

    always_comb
    begin
        count_next = count;
        if (push && !pop)
        begin
            count_next = count + 1'b1;
        end
        else if (!push && pop)
        begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            entries[wr_ptr] <= wr_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            wr_almost_full <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Leaves room for the items a sender may still push after seeing it
            wr_almost_full <= (count_next >= pw_pkg::ALMOST_FULL_LEVEL);
        end
    end

    // The stored valid bit is stale once popped, so it is rebuilt here
    always_comb
    begin
        head = entries[rd_ptr];
        head.valid = (count != '0);
    end

    // Any clear mask bit needs the old line contents first
    assign head_partial = head.valid && (head.mask != '1);

endmodule

`default_nettype wire

// ==== pw_slot_heap.sv ====
//==========================================================================
// Slot heap for parked partial writes
// Busy bit per slot with a lowest-free-slot pick, storage of the
// parked writes, and a registered fetch that releases the slot
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_slot_heap
(
    input  wire                              clk,
    input  wire                              reset,

    // Allocation toward the read path
    output logic                             slot_free,
    output logic [pw_pkg::SLOT_W-1:0]        free_slot,
    input  wire                              park_en,
    input  wire [pw_pkg::SLOT_W-1:0]         park_slot,
    input  wire pw_pkg::parked_t             park_data,

    // Retrieval toward the merge writer
    input  wire                              fetch_en,
    input  wire [pw_pkg::SLOT_W-1:0]         fetch_slot,
    output pw_pkg::parked_t                  fetched
);

    // One bit per slot, set while a partial write waits for its read data
    logic [pw_pkg::SLOTS-1:0] busy;

    pw_pkg::parked_t store [pw_pkg::SLOTS];

    //======================================================================
    // Allocation
    //======================================================================

    // Walk from the top down so the last hit is the lowest free slot
    always_comb
    begin
        slot_free = 1'b0;
        free_slot = '0;
        for (int i = pw_pkg::SLOTS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                slot_free = 1'b1;
                free_slot = i[pw_pkg::SLOT_W-1:0];
            end
        end
    end

    // Parking only ever targets a free slot and fetching only a busy one,
    // so the two updates below never touch the same bit
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= '0;
        end
        else
        begin
            if (fetch_en)
            begin
                busy[fetch_slot] <= 1'b0;
            end
            if (park_en)
            begin
                busy[park_slot] <= 1'b1;
            end
        end
    end

    //======================================================================
    // Storage
    //======================================================================

    // The write is captured in the same cycle its read is injected
    always_ff @(posedge clk)
    begin
        if (park_en)
        begin
            store[park_slot] <= park_data;
        end
    end

    // Data appears one cycle after the fetch request
    always_ff @(posedge clk)
    begin
        if (fetch_en)
        begin
            fetched <= store[fetch_slot];
        end
    end

endmodule

`default_nettype wire

// ==== pw_read_path.sv ====
//==========================================================================
// Read path of the partial-write shim
// Forwards requester reads, injects tagged line reads for partial
// writes, and steers memory responses to the requester or the merge
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_read_path
(
    input  wire                              clk,
    input  wire                              reset,

    // Requester reads
    input  wire pw_pkg::rd_req_t             rd_in,
    output logic                             rd_almost_full,

    // Memory read port
    output pw_pkg::rd_req_t                  mem_rd,
    input  wire                              mem_rd_almost_full,

    // Head of the write queue
    input  wire pw_pkg::wr_req_t             head,
    input  wire                              head_partial,
    output logic                             inject_pop,

    // Slot heap allocation
    input  wire                              slot_free,
    input  wire [pw_pkg::SLOT_W-1:0]         free_slot,
    output logic                             park_en,
    output logic [pw_pkg::SLOT_W-1:0]        park_slot,
    output pw_pkg::parked_t                  park_data,

    // Responses
    input  wire pw_pkg::rd_rsp_t             mem_rsp,
    output pw_pkg::rd_rsp_t                  rd_rsp_out,
    output pw_pkg::rd_rsp_t                  merge_rsp
);

    logic ready_q;
    logic inject;
    pw_pkg::tag_u inj_tag;

    // Memory back-pressure as seen in the previous cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_q <= 1'b0;
        end
        else
        begin
            ready_q <= !mem_rd_almost_full;
        end
    end

    // A requester read always wins the port, the injection waits for a gap
    assign inject = head_partial && !rd_in.valid && ready_q && slot_free;

    // Dequeue, park and inject all happen in one cycle
    assign inject_pop = inject;
    assign park_en = inject;
    assign park_slot = free_slot;

    always_comb
    begin
        park_data.addr = head.addr;
        park_data.data = head.data;
        park_data.mask = head.mask;
        park_data.tag = head.tag;
    end

    // Holding off the requester frees read slots for the waiting head
    assign rd_almost_full = head_partial || mem_rd_almost_full;

    //======================================================================
    // Request and response steering
    //======================================================================

    always_comb
    begin
        inj_tag = '0;
        inj_tag.view.is_merge = 1'b1;
        inj_tag.view.slot = free_slot;

        mem_rd = rd_in;
        if (inject)
        begin
            mem_rd.valid = 1'b1;
            mem_rd.addr = head.addr;
            mem_rd.tag = inj_tag;
        end
    end

    // The top tag bit tells merge traffic from requester traffic
    always_comb
    begin
        rd_rsp_out = mem_rsp;
        rd_rsp_out.valid = mem_rsp.valid && !mem_rsp.tag.view.is_merge;
        merge_rsp = mem_rsp;
        merge_rsp.valid = mem_rsp.valid && mem_rsp.tag.view.is_merge;
    end

endmodule

`default_nettype wire

// ==== pw_merge_writer.sv ====
//==========================================================================
// Merge writer of the partial-write shim
// Queues merge responses, fetches the parked write, merges old and new
// bytes, and drives the memory write port with merged lines first
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_merge_writer
(
    input  wire                              clk,
    input  wire                              reset,

    // Tagged read responses from the read path
    input  wire pw_pkg::rd_rsp_t             merge_rsp,

    // Slot heap retrieval
    output logic                             fetch_en,
    output logic [pw_pkg::SLOT_W-1:0]        fetch_slot,
    input  wire pw_pkg::parked_t             fetched,

    // Head of the write queue
    input  wire pw_pkg::wr_req_t             head,
    input  wire                              head_partial,
    output logic                             plain_pop,

    // Memory write port
    output pw_pkg::wr_req_t                  mem_wr,
    input  wire                              mem_wr_almost_full
);

    // Pending merge responses, bounded by the number of busy slots
    logic [pw_pkg::SLOT_W-1:0] rq_slot [pw_pkg::SLOTS];
    pw_pkg::line_t rq_data [pw_pkg::SLOTS];
    logic [pw_pkg::SLOT_W-1:0] rq_wr_ptr;
    logic [pw_pkg::SLOT_W-1:0] rq_rd_ptr;
    logic [pw_pkg::SLOT_W:0] rq_count;

    logic fetch_q;
    pw_pkg::line_t old_q;
    pw_pkg::line_t merged;

    //======================================================================
    // Response queue and fetch
    //======================================================================

    always_ff @(posedge clk)
    begin
        if (merge_rsp.valid)
        begin
            rq_slot[rq_wr_ptr] <= merge_rsp.tag.view.slot;
            rq_data[rq_wr_ptr] <= merge_rsp.data;
        end
        if (fetch_en)
        begin
            old_q <= rq_data[rq_rd_ptr];
        end
    end

    // A slot stays busy until its line is sure to leave, so the queue
    // can never hold more than SLOTS responses
    assign fetch_en = (rq_count != '0) && !mem_wr_almost_full;
    assign fetch_slot = rq_slot[rq_rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rq_wr_ptr <= '0;
            rq_rd_ptr <= '0;
            rq_count <= '0;
            fetch_q <= 1'b0;
        end
        else
        begin
            if (merge_rsp.valid)
            begin
                rq_wr_ptr <= rq_wr_ptr + 1'b1;
            end
            if (fetch_en)
            begin
                rq_rd_ptr <= rq_rd_ptr + 1'b1;
            end
            rq_count <= rq_count + merge_rsp.valid - fetch_en;
            fetch_q <= fetch_en;
        end
    end

    //======================================================================
    // Merge and write port
    //======================================================================

    // New bytes where the mask is set, old bytes everywhere else
    always_comb
    begin
        for (int b = 0; b < pw_pkg::DATA_BYTES; b++)
        begin
            merged[b] = fetched.mask[b] ? fetched.data[b] : old_q[b];
        end
    end

    // A merged line owns the port in the cycle after its fetch
    assign plain_pop = head.valid && !head_partial && !mem_wr_almost_full && !fetch_q;

    always_ff @(posedge clk)
    begin
        if (fetch_q)
        begin
            mem_wr.valid <= 1'b1;
            mem_wr.addr <= fetched.addr;
            mem_wr.data <= merged;
            mem_wr.mask <= '1;
            mem_wr.tag <= fetched.tag;
        end
        else
        begin
            mem_wr <= head;
            mem_wr.valid <= plain_pop;
        end
        if (reset)
        begin
            mem_wr.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== pw_shim_top.sv ====
//==========================================================================
// Top level of the partial-write shim
// Connects write queue, slot heap, read path and merge writer
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_shim_top
(
    input  wire                  clk,
    input  wire                  reset,

    // Requester side
    input  wire pw_pkg::wr_req_t wr_in,
    output logic                 wr_almost_full,
    input  wire pw_pkg::rd_req_t rd_in,
    output logic                 rd_almost_full,
    output pw_pkg::rd_rsp_t      rd_rsp_out,

    // Memory side
    output pw_pkg::rd_req_t      mem_rd,
    input  wire                  mem_rd_almost_full,
    output pw_pkg::wr_req_t      mem_wr,
    input  wire                  mem_wr_almost_full,
    input  wire pw_pkg::rd_rsp_t mem_rsp
);

    // Write queue head and its two consumers
    pw_pkg::wr_req_t head;
    logic head_partial;
    logic plain_pop;
    logic inject_pop;

    // Heap allocation and retrieval
    logic slot_free;
    logic [pw_pkg::SLOT_W-1:0] free_slot;
    logic park_en;
    logic [pw_pkg::SLOT_W-1:0] park_slot;
    pw_pkg::parked_t park_data;
    logic fetch_en;
    logic [pw_pkg::SLOT_W-1:0] fetch_slot;
    pw_pkg::parked_t fetched;

    // Responses to injected reads
    pw_pkg::rd_rsp_t merge_rsp;

    pw_write_queue write_queue
    (
        .clk, .reset,
        .wr_in, .wr_almost_full,
        .head, .head_partial, .plain_pop, .inject_pop
    );

    pw_slot_heap slot_heap
    (
        .clk, .reset,
        .slot_free, .free_slot, .park_en, .park_slot, .park_data,
        .fetch_en, .fetch_slot, .fetched
    );

    pw_read_path read_path
    (
        .clk, .reset,
        .rd_in, .rd_almost_full, .mem_rd, .mem_rd_almost_full,
        .head, .head_partial, .slot_free, .free_slot, .inject_pop,
        .park_en, .park_slot, .park_data,
        .mem_rsp, .rd_rsp_out, .merge_rsp
    );

    pw_merge_writer merge_writer
    (
        .clk, .reset,
        .merge_rsp, .fetch_en, .fetch_slot, .fetched,
        .head, .head_partial, .plain_pop,
        .mem_wr, .mem_wr_almost_full
    );

endmodule

`default_nettype wire

// ==== pw_tb_mem.sv ====
//==========================================================================
// Behavioral line memory for the partial-write shim testbench
// Address-derived fill, byte-masked write storage, and read responses
// returned after per-request delays, so they may come back out of order
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_tb_mem
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire pw_pkg::rd_req_t mem_rd,
    input  wire pw_pkg::wr_req_t mem_wr,
    input  wire [2:0]            delay_pick,
    output pw_pkg::rd_rsp_t      mem_rsp
);

    // Sixty-four lines cover every address the tests touch
    pw_pkg::line_t lines [64];

    // Reads waiting for their delay to run out
    logic pend_valid [16];
    logic [5:0] pend_addr [16];
    pw_pkg::tag_u pend_tag [16];
    logic [3:0] pend_wait [16];

    // Every byte depends on the whole line index and on its byte position
    initial
    begin
        // The response port starts idle
        mem_rsp = '0;
        for (int i = 0; i < 64; i++)
        begin
            for (int b = 0; b < pw_pkg::DATA_BYTES; b++)
            begin
                lines[i][b] = 8'(i * 37 + b * 11 + 8'h5a);
            end
        end
    end

    always @(posedge clk)
    begin : serve
        logic sent;
        logic taken;
        sent = 1'b0;
        taken = 1'b0;
        mem_rsp <= '0;
        if (reset)
        begin
            for (int i = 0; i < 16; i++)
            begin
                pend_valid[i] <= 1'b0;
            end
        end
        else
        begin
            for (int i = 0; i < 16; i++)
            begin
                // Only the lowest expired entry answers in a cycle
                if (pend_valid[i] && pend_wait[i] == 0 && !sent)
                begin
                    sent = 1'b1;
                    mem_rsp <= {1'b1, pend_tag[i], lines[pend_addr[i]]};
                    pend_valid[i] <= 1'b0;
                end
                else if (pend_valid[i] && pend_wait[i] != 0)
                begin
                    pend_wait[i] <= pend_wait[i] - 1'b1;
                end
                if (mem_rd.valid && !pend_valid[i] && !taken)
                begin
                    taken = 1'b1;
                    pend_valid[i] <= 1'b1;
                    pend_addr[i] <= mem_rd.addr[5:0];
                    pend_tag[i] <= mem_rd.tag;
                    pend_wait[i] <= {1'b0, delay_pick};
                end
            end
            if (mem_wr.valid)
            begin
                for (int b = 0; b < pw_pkg::DATA_BYTES; b++)
                begin
                    if (mem_wr.mask[b])
                    begin
                        lines[mem_wr.addr[5:0]][b] <= mem_wr.data[b];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pw_tb.sv ====
//==========================================================================
// Testbench top of the partial-write shim
// Clock and reset, LFSR draws, requester stimulus, a traffic monitor,
// checks against a shadow memory, and per-test reporting
//==========================================================================

`timescale 1ns/1ps
`default_nettype none

module pw_tb;

    logic clk;
    logic reset;
    pw_pkg::wr_req_t wr_in;
    logic wr_almost_full;
    pw_pkg::rd_req_t rd_in;
    logic rd_almost_full;
    pw_pkg::rd_rsp_t rd_rsp_out;
    pw_pkg::rd_req_t mem_rd;
    logic mem_rd_almost_full;
    pw_pkg::wr_req_t mem_wr;
    logic mem_wr_almost_full;
    pw_pkg::rd_rsp_t mem_rsp;
    logic [2:0] delay_pick;

    // Expected memory contents and the data each requester tag should return
    pw_pkg::line_t shadow [64];
    pw_pkg::line_t exp_data [128];
    logic exp_pending [128];

    // Traffic seen by the monitor
    int wr_count = 0;
    int rd_count = 0;
    int merge_rd_count = 0;
    int rsp_count = 0;
    int bp_cycles = 0;
    int bp_writes = 0;
    pw_pkg::wr_req_t last_wr;
    pw_pkg::rd_req_t last_rd;

    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] data_state = 32'he725;
    logic [31:0] delay_state = 32'he725;

    pw_shim_top uut
    (
        .clk, .reset,
        .wr_in, .wr_almost_full, .rd_in, .rd_almost_full, .rd_rsp_out,
        .mem_rd, .mem_rd_almost_full, .mem_wr, .mem_wr_almost_full, .mem_rsp
    );

    pw_tb_mem mem_model
    (
        .clk, .reset, .mem_rd, .mem_wr, .delay_pick, .mem_rsp
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //======================================================================
    // Random numbers and checking helpers
    //======================================================================

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    // The bit taken is the one shifted out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[62:0], data_state[0]};
            data_state = lfsr_step(data_state);
        end
    endtask

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else
        begin
            $display("Mismatch at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors)
        begin
            $display("Test %0d %s: ok", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    task automatic check_lines(input int first, input int n);
        for (int a = first; a < first + n; a++)
        begin
            expect_true(mem_model.lines[a] == shadow[a], $sformatf("line %0d differs", a));
        end
    endtask

    // Memory delays come from their own LFSR so they never shift the data draws
    always @(negedge clk)
    begin : delay_draw
        logic [2:0] pick;
        pick = '0;
        for (int i = 0; i < 3; i++)
        begin
            pick = {pick[1:0], delay_state[0]};
            delay_state = lfsr_step(delay_state);
        end
        delay_pick = pick;
    end

    //======================================================================
    // Monitor
    //======================================================================

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (mem_wr.valid)
            begin
                wr_count++;
                last_wr = mem_wr;
            end
            if (mem_rd.valid)
            begin
                rd_count++;
                last_rd = mem_rd;
                if (mem_rd.tag.view.is_merge)
                begin
                    merge_rd_count++;
                end
            end
            if (rd_rsp_out.valid)
            begin
                rsp_count++;
                expect_true(!rd_rsp_out.tag.view.is_merge, "merge response reached requester");
                expect_true(exp_pending[rd_rsp_out.tag.opaque[6:0]], "unexpected response tag");
                expect_true(rd_rsp_out.data == exp_data[rd_rsp_out.tag.opaque[6:0]],
                            "read data differs from shadow");
                exp_pending[rd_rsp_out.tag.opaque[6:0]] = 1'b0;
            end
            // At most two writes may still leave after back-pressure rises
            if (mem_wr_almost_full)
            begin
                bp_cycles++;
                if (mem_wr.valid)
                begin
                    bp_writes++;
                    expect_true(bp_cycles <= 2, "write left after back-pressure allowance");
                end
            end
            else
            begin
                bp_cycles = 0;
            end
        end
    end

    //======================================================================
    // Stimulus tasks driven on the falling edge
    //======================================================================

    task automatic send_write(input int a, input pw_pkg::line_t d, input pw_pkg::mask_t m,
                              input logic [7:0] t);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wr_almost_full && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        if (wr_almost_full)
        begin
            $display("Timeout: the write queue stayed almost full");
            errors++;
        end
        wr_in = '0;
        wr_in.valid = 1'b1;
        wr_in.addr = a;
        wr_in.data = d;
        wr_in.mask = m;
        wr_in.tag.opaque = t;
        for (int b = 0; b < pw_pkg::DATA_BYTES; b++)
        begin
            if (m[b])
            begin
                shadow[a][b] = d[b];
            end
        end
        @(negedge clk);
        wr_in.valid = 1'b0;
    endtask

    task automatic send_read(input int a, input logic [7:0] t);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (rd_almost_full && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rd_almost_full)
        begin
            $display("Timeout: the read port stayed almost full");
            errors++;
        end
        exp_data[t[6:0]] = shadow[a];
        exp_pending[t[6:0]] = 1'b1;
        rd_in = '0;
        rd_in.valid = 1'b1;
        rd_in.addr = a;
        rd_in.tag.opaque = t;
        @(negedge clk);
        rd_in.valid = 1'b0;
    endtask

    task automatic wait_for_writes(input int target);
        int cycles;
        cycles = 0;
        while (wr_count < target && cycles < 400)
        begin
            @(negedge clk);
            cycles++;
        end
        if (wr_count < target)
        begin
            $display("Timeout: only %0d memory writes seen, %0d expected", wr_count, target);
            errors++;
        end
    endtask

    task automatic wait_for_responses(input int target);
        int cycles;
        cycles = 0;
        while (rsp_count < target && cycles < 400)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rsp_count < target)
        begin
            $display("Timeout: only %0d read responses seen, %0d expected", rsp_count, target);
            errors++;
        end
    endtask

    //======================================================================
    // Test sequence
    //======================================================================

    initial
    begin : run
        logic [63:0] rnd;
        logic [63:0] mrnd;
        int wstart;
        int rstart;
        int mstart;
        int qstart;
        reset = 1'b1;
        wr_in = '0;
        rd_in = '0;
        mem_rd_almost_full = 1'b0;
        mem_wr_almost_full = 1'b0;
        for (int i = 0; i < 128; i++)
        begin
            exp_pending[i] = 1'b0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 64; i++)
        begin
            shadow[i] = mem_model.lines[i];
        end

        // Quiet outputs right after reset
        expect_true(!mem_wr.valid && !mem_rd.valid && !rd_rsp_out.valid, "valid high after reset");
        expect_true(!wr_almost_full && !rd_almost_full, "almost-full high after reset");
        finish_test("reset state");

        // Full-mask write goes straight to the write port
        wstart = wr_count;
        rstart = rd_count;
        draw_bits(64, rnd);
        send_write(2, rnd, 8'hff, 8'h12);
        wait_for_writes(wstart + 1);
        expect_true(last_wr.addr == 32'd2 && last_wr.data == rnd, "full write address or data");
        expect_true(last_wr.mask == 8'hff && last_wr.tag.opaque == 8'h12, "full write mask or tag");
        expect_true(rd_count == rstart, "full write caused a memory read");
        finish_test("full-line write");

        // Partial write goes through read, merge and full-line write
        wstart = wr_count;
        rstart = rd_count;
        mstart = merge_rd_count;
        qstart = rsp_count;
        draw_bits(64, rnd);
        send_write(3, rnd, 8'h3c, 8'h13);
        wait_for_writes(wstart + 1);
        expect_true(rd_count == rstart + 1 && merge_rd_count == mstart + 1, "injected read count");
        expect_true(last_rd.addr == 32'd3 && last_rd.tag.view.is_merge, "injected read tag");
        expect_true(rsp_count == qstart, "merge response reached requester");
        expect_true(last_wr.addr == 32'd3 && last_wr.mask == 8'hff, "merged write address or mask");
        expect_true(last_wr.data == shadow[3] && last_wr.tag.opaque == 8'h13, "merged bytes");
        check_lines(3, 1);
        finish_test("partial write");

        qstart = rsp_count;
        send_read(4, 8'h24);
        wait_for_responses(qstart + 1);
        expect_true(!exp_pending[8'h24], "requester read tag not returned");
        finish_test("requester read");

        // Every slot in use with requester reads in between
        wstart = wr_count;
        qstart = rsp_count;
        for (int i = 0; i < pw_pkg::SLOTS; i++)
        begin
            draw_bits(64, rnd);
            draw_bits(8, mrnd);
            if (mrnd[7:0] == 8'hff)
            begin
                mrnd[7:0] = 8'h7f;
            end
            send_write(8 + i, rnd, mrnd[7:0], 8'h50 + i);
            send_read(16 + i, 8'h40 + i);
        end
        wait_for_writes(wstart + pw_pkg::SLOTS);
        wait_for_responses(qstart + pw_pkg::SLOTS);
        check_lines(8, pw_pkg::SLOTS);
        check_lines(16, pw_pkg::SLOTS);
        finish_test("mixed traffic");

        // Write back-pressure raised while lines are still on their way
        wstart = wr_count;
        draw_bits(64, rnd);
        send_write(24, rnd, 8'hff, 8'h61);
        draw_bits(64, rnd);
        send_write(25, rnd, 8'hf0, 8'h62);
        draw_bits(64, rnd);
        send_write(26, rnd, 8'hff, 8'h63);
        draw_bits(64, rnd);
        send_write(27, rnd, 8'h0f, 8'h64);
        bp_writes = 0;
        mem_wr_almost_full = 1'b1;
        repeat (40) @(negedge clk);
        expect_true(bp_writes <= 2, "too many writes under back-pressure");
        mem_wr_almost_full = 1'b0;
        wait_for_writes(wstart + 4);
        check_lines(24, 4);
        finish_test("write back-pressure");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
pw_pkg.sv
pw_write_queue.sv
pw_slot_heap.sv
pw_read_path.sv
pw_merge_writer.sv
pw_shim_top.sv
pw_tb_mem.sv
pw_tb.sv

// ==== Bender.yml ====
package:
  name: pw_shim

sources:
  - files:
      - pw_pkg.sv
      - pw_write_queue.sv
      - pw_slot_heap.sv
      - pw_read_path.sv
      - pw_merge_writer.sv
      - pw_shim_top.sv
  - target: test
    files:
      - pw_tb_mem.sv
      - pw_tb.sv
